// File: src.f
axi_pkg.sv
axi_mem_pkg.sv
axi_skid_buf.sv
axi_mem_array.sv
axi_mem_wr.sv
axi_mem_rd.sv
axi_mem.sv
tb_axi_mem.sv

// File: Makefile
# Verilator simulation of the AXI memory testbench

VERILATOR ?= verilator
TOP       ?= tb_axi_mem
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: sim clean

# Builds and runs; a failing run exits with a nonzero status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: tb_axi_mem.sv
`default_nettype none

module tb_axi_mem;

  timeunit 1ns;
  timeprecision 1ps;

  import axi_pkg::*;
  import axi_mem_pkg::*;

  localparam int ADDR_WIDTH = DEF_ADDR_WIDTH;
  localparam int DATA_WIDTH = DEF_DATA_WIDTH;
  localparam int ID_WIDTH   = DEF_ID_WIDTH;
  localparam int STRB_W     = DATA_WIDTH / 8;
  localparam int OFFSET_W   = $clog2(STRB_W);
  localparam int WORD_AW    = ADDR_WIDTH - OFFSET_W;
  localparam int WORDS      = 2 ** WORD_AW;

  localparam logic [SIZE_WIDTH-1:0]  FULL_SIZE  = SIZE_WIDTH'(OFFSET_W);
  localparam logic [ADDR_WIDTH-1:0]  STEP       = ADDR_WIDTH'(1) << FULL_SIZE;
  localparam logic [BURST_WIDTH-1:0] BURST_INCR = 2'b01;
  localparam logic [31:0]            SEED       = 32'h6390b8a1;
  localparam int                     NUM_INCR   = 6;
  localparam int                     NUM_BP     = 5;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   awvalid;
  logic [ID_WIDTH-1:0]    awid;
  logic [ADDR_WIDTH-1:0]  awaddr;
  logic [SIZE_WIDTH-1:0]  awsize;
  logic [BURST_WIDTH-1:0] awburst;
  logic                   awready;
  logic                   wvalid;
  logic [DATA_WIDTH-1:0]  wdata;
  logic [STRB_W-1:0]      wstrb;
  logic                   wlast;
  logic                   wready;
  logic                   bvalid;
  logic [ID_WIDTH-1:0]    bid;
  logic [RESP_WIDTH-1:0]  bresp;
  logic                   bready;
  logic                   arvalid;
  logic [ID_WIDTH-1:0]    arid;
  logic [ADDR_WIDTH-1:0]  araddr;
  logic [LEN_WIDTH-1:0]   arlen;
  logic [SIZE_WIDTH-1:0]  arsize;
  logic [BURST_WIDTH-1:0] arburst;
  logic                   arready;
  logic                   rvalid;
  logic [ID_WIDTH-1:0]    rid;
  logic [DATA_WIDTH-1:0]  rdata;
  logic [RESP_WIDTH-1:0]  rresp;
  logic                   rlast;
  logic                   rready;

  // Reference model and expected responses
  logic [DATA_WIDTH-1:0] ref_mem [WORDS];
  logic [ID_WIDTH-1:0]   exp_bid [$];
  logic [ID_WIDTH-1:0]   exp_rid [$];
  logic [DATA_WIDTH-1:0] exp_rdata [$];
  logic                  exp_rlast [$];

  bit                    bp_on;
  bit                    gaps_on;
  int                    cycle_count;
  int                    cycle_limit;
  int                    incr_len [NUM_INCR];
  int                    bp_len [NUM_BP];
  logic [ADDR_WIDTH-1:0] bp_addr [NUM_BP];

  axi_mem #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .ID_WIDTH  (ID_WIDTH)
  ) i_dut (
    .i_clk    (clk),
    .rst_n    (rst_n),
    .i_awvalid(awvalid),
    .i_awid   (awid),
    .i_awaddr (awaddr),
    .i_awsize (awsize),
    .i_awburst(awburst),
    .o_awready(awready),
    .i_wvalid (wvalid),
    .i_wdata  (wdata),
    .i_wstrb  (wstrb),
    .i_wlast  (wlast),
    .o_wready (wready),
    .o_bvalid (bvalid),
    .o_bid    (bid),
    .o_bresp  (bresp),
    .i_bready (bready),
    .i_arvalid(arvalid),
    .i_arid   (arid),
    .i_araddr (araddr),
    .i_arlen  (arlen),
    .i_arsize (arsize),
    .i_arburst(arburst),
    .o_arready(arready),
    .o_rvalid (rvalid),
    .o_rid    (rid),
    .o_rdata  (rdata),
    .o_rresp  (rresp),
    .o_rlast  (rlast),
    .i_rready (rready)
  );

  initial begin
    forever begin
      #50 clk = ~clk;
    end
  end

  // --------------------------------------------------
  // Reference model and checking helpers
  // --------------------------------------------------
  // Expected word at a byte address
  function automatic logic [DATA_WIDTH-1:0] expected_word(input logic [ADDR_WIDTH-1:0] addr);
    return ref_mem[addr[ADDR_WIDTH-1:OFFSET_W]];
  endfunction

  function automatic logic [DATA_WIDTH-1:0] merge_bytes(input logic [DATA_WIDTH-1:0] old_word,
                                                        input logic [DATA_WIDTH-1:0] new_word,
                                                        input logic [STRB_W-1:0]     strb);
    logic [DATA_WIDTH-1:0] result;
    result = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  // Initial contents where every byte depends on the word index
  function automatic logic [DATA_WIDTH-1:0] fill_word(input int idx);
    return {8'(idx), 8'(~idx), 8'(idx * 7 + 3), 8'(idx ^ 8'h5A)};
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("ERROR: %s = 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // --------------------------------------------------
  // Response monitors
  // --------------------------------------------------
  initial begin
    bready = 1'b0;
    forever begin
      @(negedge clk);
      bready = bp_on ? ($urandom_range(0, 1) == 1) : 1'b1;
      if (rst_n && bvalid && bready) begin
        if (exp_bid.size() == 0) begin
          stop_with_failure("Write response arrived with no write burst pending");
        end else begin
          check_value("BID", 64'(bid), 64'(exp_bid.pop_front()));
          check_value("BRESP", 64'(bresp), 64'(RESP_OKAY));
        end
      end
    end
  end

  initial begin
    rready = 1'b0;
    forever begin
      @(negedge clk);
      rready = bp_on ? ($urandom_range(0, 1) == 1) : 1'b1;
      if (rst_n && rvalid && rready) begin
        if (exp_rdata.size() == 0) begin
          stop_with_failure("Read beat arrived with no read burst pending");
        end else begin
          check_value("RID", 64'(rid), 64'(exp_rid.pop_front()));
          check_value("RDATA", 64'(rdata), 64'(exp_rdata.pop_front()));
          check_value("RLAST", 64'(rlast), 64'(exp_rlast.pop_front()));
          check_value("RRESP", 64'(rresp), 64'(RESP_OKAY));
        end
      end
    end
  end

  // Limit is set by the main process once the burst lengths are known
  initial begin
    cycle_count = 0;
    while (cycle_count <= cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    stop_with_failure($sformatf("Timeout after %0d cycles, a transfer never completed",
                                cycle_count));
  end

  // --------------------------------------------------
  // Bus drivers
  // --------------------------------------------------
  task automatic write_burst(input logic [ID_WIDTH-1:0] id, input logic [ADDR_WIDTH-1:0] addr,
                             input logic [BURST_WIDTH-1:0] burst, input int beats,
                             input bit rand_strb, input bit pattern);
    logic [ADDR_WIDTH-1:0] w_addr;
    bit                    aw_hs;
    bit                    w_hs;
    exp_bid.push_back(id);
    w_addr = addr;
    fork
      begin
        awvalid = 1'b1;
        awid    = id;
        awaddr  = addr;
        awsize  = FULL_SIZE;
        awburst = burst;
        do begin
          aw_hs = awready;
          @(negedge clk);
        end while (!aw_hs);
        awvalid = 1'b0;
      end
      begin
        for (int i = 0; i < beats; i++) begin
          wvalid = 1'b0;
          while (gaps_on && $urandom_range(0, 2) == 0) begin
            @(negedge clk);
          end
          wdata  = pattern ? fill_word(int'(w_addr[ADDR_WIDTH-1:OFFSET_W]))
                           : DATA_WIDTH'($urandom);
          wstrb  = rand_strb ? STRB_W'($urandom) : {STRB_W{1'b1}};
          wlast  = (i == beats - 1);
          wvalid = 1'b1;
          do begin
            w_hs = wready;
            @(negedge clk);
          end while (!w_hs);
          // Mirror the accepted beat
          ref_mem[w_addr[ADDR_WIDTH-1:OFFSET_W]] =
            merge_bytes(ref_mem[w_addr[ADDR_WIDTH-1:OFFSET_W]], wdata, wstrb);
          if (burst != BURST_FIXED) begin
            w_addr = w_addr + STEP;
          end
        end
        wvalid = 1'b0;
      end
    join
  endtask

  task automatic wait_write_responses();
    while (exp_bid.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic read_burst(input logic [ID_WIDTH-1:0] id, input logic [ADDR_WIDTH-1:0] addr,
                            input logic [BURST_WIDTH-1:0] burst, input int beats);
    logic [ADDR_WIDTH-1:0] r_addr;
    bit                    ar_hs;
    r_addr = addr;
    for (int i = 0; i < beats; i++) begin
      exp_rid.push_back(id);
      exp_rdata.push_back(expected_word(r_addr));
      exp_rlast.push_back(i == beats - 1);
      if (burst != BURST_FIXED) begin
        r_addr = r_addr + STEP;
      end
    end
    arvalid = 1'b1;
    arid    = id;
    araddr  = addr;
    arlen   = LEN_WIDTH'(beats - 1);
    arsize  = FULL_SIZE;
    arburst = burst;
    do begin
      ar_hs = arready;
      @(negedge clk);
    end while (!ar_hs);
    arvalid = 1'b0;
    while (exp_rdata.size() != 0) begin
      @(negedge clk);
    end
  endtask

  function automatic logic [ADDR_WIDTH-1:0] random_addr();
    return ADDR_WIDTH'($urandom_range(0, WORDS - 1)) << OFFSET_W;
  endfunction

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin
    int                    planned_beats;
    logic [ADDR_WIDTH-1:0] addr;
    void'($urandom(SEED));
    rst_n   = 1'b0;
    awvalid = 1'b0;
    awid    = '0;
    awaddr  = '0;
    awsize  = '0;
    awburst = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wlast   = 1'b0;
    arvalid = 1'b0;
    arid    = '0;
    araddr  = '0;
    arlen   = '0;
    arsize  = '0;
    arburst = '0;
    bp_on   = 1'b0;
    gaps_on = 1'b0;

    // Burst lengths up front so the timeout can be sized
    planned_beats = 2 + WORDS + 9;
    for (int k = 0; k < NUM_INCR; k++) begin
      incr_len[k]   = int'($urandom_range(1, 16));
      planned_beats = planned_beats + 2 * incr_len[k];
    end
    for (int k = 0; k < NUM_BP; k++) begin
      bp_len[k]     = int'($urandom_range(1, 12));
      planned_beats = planned_beats + 2 * bp_len[k];
    end
    cycle_limit = 40 * planned_beats + 200;

    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    // Reset state
    check_value("BVALID", 64'(bvalid), 64'(1'b0));
    check_value("RVALID", 64'(rvalid), 64'(1'b0));
    check_value("ARREADY", 64'(arready), 64'(1'b1));
    @(negedge clk);
    check_value("AWREADY", 64'(awready), 64'(1'b1));
    check_value("WREADY", 64'(wready), 64'(1'b1));

    // Single beat with all strobes
    addr = random_addr();
    write_burst(ID_WIDTH'($urandom), addr, BURST_INCR, 1, 1'b0, 1'b0);
    wait_write_responses();
    read_burst(ID_WIDTH'($urandom), addr, BURST_INCR, 1);

    // Defined contents everywhere before partial-strobe writes
    write_burst(ID_WIDTH'($urandom), '0, BURST_INCR, WORDS, 1'b0, 1'b1);
    wait_write_responses();

    for (int k = 0; k < NUM_INCR; k++) begin
      addr = random_addr();
      write_burst(ID_WIDTH'($urandom), addr, BURST_INCR, incr_len[k], 1'b1, 1'b0);
      wait_write_responses();
      read_burst(ID_WIDTH'($urandom), addr, BURST_INCR, incr_len[k]);
    end

    // FIXED bursts merge into one word
    addr = random_addr();
    write_burst(ID_WIDTH'($urandom), addr, BURST_FIXED, 5, 1'b1, 1'b0);
    wait_write_responses();
    read_burst(ID_WIDTH'($urandom), addr, BURST_FIXED, 4);

    // Back-pressure and data gaps with writes issued back to back
    bp_on   = 1'b1;
    gaps_on = 1'b1;
    for (int k = 0; k < NUM_BP; k++) begin
      bp_addr[k] = random_addr();
      write_burst(ID_WIDTH'($urandom), bp_addr[k], BURST_INCR, bp_len[k], 1'b1, 1'b0);
    end
    wait_write_responses();
    for (int k = 0; k < NUM_BP; k++) begin
      read_burst(ID_WIDTH'($urandom), bp_addr[k], BURST_INCR, bp_len[k]);
    end
    repeat (5) @(negedge clk);

    if (exp_bid.size() != 0 || exp_rdata.size() != 0) begin
      stop_with_failure("Responses still pending at the end of the run");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: axi_mem.sv
`default_nettype none

// AXI4 subordinate backed by on-chip memory
module axi_mem #(
  parameter int  ADDR_WIDTH      = axi_mem_pkg::DEF_ADDR_WIDTH,
  parameter int  DATA_WIDTH      = axi_mem_pkg::DEF_DATA_WIDTH,
  parameter int  ID_WIDTH        = axi_mem_pkg::DEF_ID_WIDTH,
  localparam int STRB_WIDTH      = DATA_WIDTH / 8,
  localparam int OFFSET_WIDTH    = $clog2(STRB_WIDTH),
  localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - OFFSET_WIDTH
) (
  input  logic                            i_clk,
  input  logic                            rst_n,

  // Write address
  input  logic                            i_awvalid,
  input  logic [ID_WIDTH-1:0]             i_awid,
  input  logic [ADDR_WIDTH-1:0]           i_awaddr,
  input  logic [axi_pkg::SIZE_WIDTH-1:0]  i_awsize,
  input  logic [axi_pkg::BURST_WIDTH-1:0] i_awburst,
  output logic                            o_awready,

  // Write data
  input  logic                            i_wvalid,
  input  logic [DATA_WIDTH-1:0]           i_wdata,
  input  logic [STRB_WIDTH-1:0]           i_wstrb,
  input  logic                            i_wlast,
  output logic                            o_wready,

  // Write response
  output logic                            o_bvalid,
  output logic [ID_WIDTH-1:0]             o_bid,
  output logic [axi_pkg::RESP_WIDTH-1:0]  o_bresp,
  input  logic                            i_bready,

  // Read address
  input  logic                            i_arvalid,
  input  logic [ID_WIDTH-1:0]             i_arid,
  input  logic [ADDR_WIDTH-1:0]           i_araddr,
  input  logic [axi_pkg::LEN_WIDTH-1:0]   i_arlen,
  input  logic [axi_pkg::SIZE_WIDTH-1:0]  i_arsize,
  input  logic [axi_pkg::BURST_WIDTH-1:0] i_arburst,
  output logic                            o_arready,

  // Read data
  output logic                            o_rvalid,
  output logic [ID_WIDTH-1:0]             o_rid,
  output logic [DATA_WIDTH-1:0]           o_rdata,
  output logic [axi_pkg::RESP_WIDTH-1:0]  o_rresp,
  output logic                            o_rlast,
  input  logic                            i_rready
);

  import axi_pkg::*;

  logic                       mem_we;
  logic [WORD_ADDR_WIDTH-1:0] mem_waddr;
  logic [DATA_WIDTH-1:0]      mem_wdata;
  logic [STRB_WIDTH-1:0]      mem_wstrb;
  logic                       mem_re;
  logic [WORD_ADDR_WIDTH-1:0] mem_raddr;

  // No error cases, every access succeeds
  assign o_bresp = RESP_OKAY;
  assign o_rresp = RESP_OKAY;

  axi_mem_wr #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .ID_WIDTH  (ID_WIDTH)
  ) u_wr (
    .clk        (i_clk),
    .rst_n      (rst_n),
    .i_awvalid  (i_awvalid),
    .i_awid     (i_awid),
    .i_awaddr   (i_awaddr),
    .i_awsize   (i_awsize),
    .i_awburst  (i_awburst),
    .o_awready  (o_awready),
    .i_wvalid   (i_wvalid),
    .i_wdata    (i_wdata),
    .i_wstrb    (i_wstrb),
    .i_wlast    (i_wlast),
    .o_wready   (o_wready),
    .o_bvalid   (o_bvalid),
    .o_bid      (o_bid),
    .i_bready   (i_bready),
    .o_mem_we   (mem_we),
    .o_mem_waddr(mem_waddr),
    .o_mem_wdata(mem_wdata),
    .o_mem_wstrb(mem_wstrb)
  );

  axi_mem_rd #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .ID_WIDTH  (ID_WIDTH)
  ) u_rd (
    .clk        (i_clk),
    .rst_n      (rst_n),
    .i_arvalid  (i_arvalid),
    .i_arid     (i_arid),
    .i_araddr   (i_araddr),
    .i_arlen    (i_arlen),
    .i_arsize   (i_arsize),
    .i_arburst  (i_arburst),
    .o_arready  (o_arready),
    .o_rvalid   (o_rvalid),
    .o_rid      (o_rid),
    .o_rlast    (o_rlast),
    .i_rready   (i_rready),
    .o_mem_re   (mem_re),
    .o_mem_raddr(mem_raddr)
  );

  axi_mem_array #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) u_array (
    .clk    (i_clk),
    .i_we   (mem_we),
    .i_waddr(mem_waddr),
    .i_wdata(mem_wdata),
    .i_wstrb(mem_wstrb),
    .i_re   (mem_re),
    .i_raddr(mem_raddr),
    .o_rdata(o_rdata)
  );

endmodule

`default_nettype wire

// File: axi_mem_rd.sv
`default_nettype none

// Read engine: AR capture, beat counting, address stepping, R control
module axi_mem_rd #(
  parameter int  ADDR_WIDTH      = 8,
  parameter int  DATA_WIDTH      = 32,
  parameter int  ID_WIDTH        = 4,
  localparam int STRB_WIDTH      = DATA_WIDTH / 8,
  localparam int OFFSET_WIDTH    = $clog2(STRB_WIDTH),
  localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - OFFSET_WIDTH
) (
  input  logic                            clk,
  input  logic                            rst_n,

  input  logic                            i_arvalid,
  input  logic [ID_WIDTH-1:0]             i_arid,
  input  logic [ADDR_WIDTH-1:0]           i_araddr,
  input  logic [axi_pkg::LEN_WIDTH-1:0]   i_arlen,
  input  logic [axi_pkg::SIZE_WIDTH-1:0]  i_arsize,
  input  logic [axi_pkg::BURST_WIDTH-1:0] i_arburst,
  output logic                            o_arready,

  output logic                            o_rvalid,
  output logic [ID_WIDTH-1:0]             o_rid,
  output logic                            o_rlast,
  input  logic                            i_rready,

  output logic                            o_mem_re,
  output logic [WORD_ADDR_WIDTH-1:0]      o_mem_raddr
);

  import axi_pkg::*;
  import axi_mem_pkg::*;

  rd_state_e              state;
  rd_state_e              state_next;
  logic [ID_WIDTH-1:0]    r_id;
  logic [ID_WIDTH-1:0]    r_id_next;
  logic [ADDR_WIDTH-1:0]  r_addr;
  logic [ADDR_WIDTH-1:0]  r_addr_next;
  logic [LEN_WIDTH-1:0]   r_len;
  logic [LEN_WIDTH-1:0]   r_len_next;
  logic [SIZE_WIDTH-1:0]  r_size;
  logic [SIZE_WIDTH-1:0]  r_size_next;
  logic [BURST_WIDTH-1:0] r_burst;
  logic [BURST_WIDTH-1:0] r_burst_next;

  logic                   idle;
  logic [ID_WIDTH-1:0]    cur_id;
  logic [ADDR_WIDTH-1:0]  cur_addr;
  logic [LEN_WIDTH-1:0]   cur_len;
  logic [SIZE_WIDTH-1:0]  cur_size;
  logic [BURST_WIDTH-1:0] cur_burst;

  logic                   launch;
  logic                   arready_next;
  logic                   rvalid_next;
  logic [ID_WIDTH-1:0]    rid_next;
  logic                   rlast_next;

  // First beat of a burst uses the AR fields directly
  assign idle      = (state == RD_IDLE);
  assign cur_id    = idle ? i_arid : r_id;
  assign cur_addr  = idle ? i_araddr : r_addr;
  assign cur_len   = idle ? i_arlen : r_len;
  assign cur_size  = idle ? i_arsize : r_size;
  assign cur_burst = idle ? i_arburst : r_burst;

  assign o_mem_raddr = cur_addr[ADDR_WIDTH-1:OFFSET_WIDTH];

  always_comb begin
    state_next   = state;
    r_id_next    = r_id;
    r_addr_next  = r_addr;
    r_len_next   = r_len;
    r_size_next  = r_size;
    r_burst_next = r_burst;
    arready_next = o_arready;
    rvalid_next  = o_rvalid && !i_rready;
    rid_next     = o_rid;
    rlast_next   = o_rlast;
    launch       = 1'b0;

    case (state)
      RD_IDLE: begin
        if (i_arvalid && o_arready) begin
          state_next   = RD_BURST;
          arready_next = 1'b0;
          r_id_next    = i_arid;
          r_addr_next  = i_araddr;
          r_len_next   = i_arlen;
          r_size_next  = i_arsize;
          r_burst_next = i_arburst;
          launch       = !o_rvalid || i_rready;
        end
      end
      RD_BURST: begin
        launch = !o_rvalid || i_rready;
      end
      default: begin
        state_next = RD_IDLE;
      end
    endcase

    // ------------------------------------------------
    // Beat launch into a free R slot
    // ------------------------------------------------
    if (launch) begin
      rvalid_next = 1'b1;
      rid_next    = cur_id;
      rlast_next  = (cur_len == '0);
      r_len_next  = cur_len - LEN_WIDTH'(1);
      if (cur_burst != BURST_FIXED) begin
        r_addr_next = cur_addr + (ADDR_WIDTH'(1) << cur_size);
      end
      if (cur_len == '0) begin
        state_next   = RD_IDLE;
        arready_next = 1'b1;
      end
    end
  end

  assign o_mem_re = launch;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= RD_IDLE;
      o_arready <= 1'b1;
      o_rvalid  <= 1'b0;
    end else begin
      state     <= state_next;
      o_arready <= arready_next;
      o_rvalid  <= rvalid_next;
    end
  end

  always_ff @(posedge clk) begin
    r_id    <= r_id_next;
    r_addr  <= r_addr_next;
    r_len   <= r_len_next;
    r_size  <= r_size_next;
    r_burst <= r_burst_next;
    o_rid   <= rid_next;
    o_rlast <= rlast_next;
  end

endmodule

`default_nettype wire

// File: axi_mem_wr.sv
`default_nettype none

// Write engine: AW and W skid buffers, burst stepping, B response
module axi_mem_wr #(
  parameter int  ADDR_WIDTH      = 8,
  parameter int  DATA_WIDTH      = 32,
  parameter int  ID_WIDTH        = 4,
  localparam int STRB_WIDTH      = DATA_WIDTH / 8,
  localparam int OFFSET_WIDTH    = $clog2(STRB_WIDTH),
  localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - OFFSET_WIDTH
) (
  input  logic                         clk,
  input  logic                         rst_n,

  input  logic                         i_awvalid,
  input  logic [ID_WIDTH-1:0]          i_awid,
  input  logic [ADDR_WIDTH-1:0]        i_awaddr,
  input  logic [axi_pkg::SIZE_WIDTH-1:0]  i_awsize,
  input  logic [axi_pkg::BURST_WIDTH-1:0] i_awburst,
  output logic                         o_awready,

  input  logic                         i_wvalid,
  input  logic [DATA_WIDTH-1:0]        i_wdata,
  input  logic [STRB_WIDTH-1:0]        i_wstrb,
  input  logic                         i_wlast,
  output logic                         o_wready,

  output logic                         o_bvalid,
  output logic [ID_WIDTH-1:0]          o_bid,
  input  logic                         i_bready,

  output logic                         o_mem_we,
  output logic [WORD_ADDR_WIDTH-1:0]   o_mem_waddr,
  output logic [DATA_WIDTH-1:0]        o_mem_wdata,
  output logic [STRB_WIDTH-1:0]        o_mem_wstrb
);

  import axi_pkg::*;
  import axi_mem_pkg::*;

  typedef struct packed {
    logic [ID_WIDTH-1:0]    id;
    logic [ADDR_WIDTH-1:0]  addr;
    logic [SIZE_WIDTH-1:0]  size;
    logic [BURST_WIDTH-1:0] burst;
  } aw_beat_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
    logic                  last;
  } w_beat_t;

  aw_beat_t               aw_q;
  logic                   aw_valid;
  logic                   aw_ready;
  w_beat_t                w_q;
  logic                   w_valid;
  logic                   w_ready;

  wr_state_e              state;
  wr_state_e              state_next;
  logic [ID_WIDTH-1:0]    bst_id;
  logic [ID_WIDTH-1:0]    bst_id_next;
  logic [ADDR_WIDTH-1:0]  bst_addr;
  logic [ADDR_WIDTH-1:0]  bst_addr_next;
  logic [SIZE_WIDTH-1:0]  bst_size;
  logic [SIZE_WIDTH-1:0]  bst_size_next;
  logic [BURST_WIDTH-1:0] bst_burst;
  logic [BURST_WIDTH-1:0] bst_burst_next;

  logic [ID_WIDTH-1:0]    cur_id;
  logic [ADDR_WIDTH-1:0]  cur_addr;
  logic [SIZE_WIDTH-1:0]  cur_size;
  logic [BURST_WIDTH-1:0] cur_burst;

  logic                   b_free;
  logic                   bvalid_next;
  logic [ID_WIDTH-1:0]    bid_next;

  // --------------------------------------------------
  // Input skid buffers
  // --------------------------------------------------
  axi_skid_buf #(
    .payload_t(aw_beat_t)
  ) u_aw_skid (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_valid(i_awvalid),
    .i_data ({i_awid, i_awaddr, i_awsize, i_awburst}),
    .o_ready(o_awready),
    .o_valid(aw_valid),
    .o_data (aw_q),
    .i_ready(aw_ready)
  );

  axi_skid_buf #(
    .payload_t(w_beat_t)
  ) u_w_skid (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_valid(i_wvalid),
    .i_data ({i_wdata, i_wstrb, i_wlast}),
    .o_ready(o_wready),
    .o_valid(w_valid),
    .o_data (w_q),
    .i_ready(w_ready)
  );

  // --------------------------------------------------
  // Burst state machine
  // --------------------------------------------------
  // While idle the first beat uses the fields straight from AW
  assign cur_id    = (state == WR_IDLE) ? aw_q.id : bst_id;
  assign cur_addr  = (state == WR_IDLE) ? aw_q.addr : bst_addr;
  assign cur_size  = (state == WR_IDLE) ? aw_q.size : bst_size;
  assign cur_burst = (state == WR_IDLE) ? aw_q.burst : bst_burst;

  // B slot is free when empty or being emptied now
  assign b_free = !o_bvalid || i_bready;

  assign o_mem_waddr = cur_addr[ADDR_WIDTH-1:OFFSET_WIDTH];
  assign o_mem_wdata = w_q.data;
  assign o_mem_wstrb = w_q.strb;

  always_comb begin
    state_next     = state;
    bst_id_next    = bst_id;
    bst_addr_next  = bst_addr;
    bst_size_next  = bst_size;
    bst_burst_next = bst_burst;
    bvalid_next    = o_bvalid && !i_bready;
    bid_next       = o_bid;
    aw_ready       = 1'b0;
    w_ready        = 1'b0;
    o_mem_we       = 1'b0;

    case (state)
      WR_IDLE: begin
        aw_ready = 1'b1;
        if (aw_valid) begin
          state_next     = WR_BURST;
          bst_id_next    = aw_q.id;
          bst_addr_next  = aw_q.addr;
          bst_size_next  = aw_q.size;
          bst_burst_next = aw_q.burst;
          w_ready        = b_free;
        end
      end
      WR_BURST: begin
        w_ready = b_free;
      end
      WR_RESP: begin
        if (b_free) begin
          state_next  = WR_IDLE;
          bvalid_next = 1'b1;
          bid_next    = bst_id;
        end
      end
      default: begin
        state_next = WR_IDLE;
      end
    endcase

    // Accepted data beat, written in its handshake cycle
    if (w_valid && w_ready) begin
      o_mem_we = 1'b1;
      if (cur_burst != BURST_FIXED) begin
        bst_addr_next = cur_addr + (ADDR_WIDTH'(1) << cur_size);
      end
      if (w_q.last) begin
        if (b_free) begin
          state_next  = WR_IDLE;
          bvalid_next = 1'b1;
          bid_next    = cur_id;
        end else begin
          state_next = WR_RESP;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= WR_IDLE;
      o_bvalid <= 1'b0;
    end else begin
      state    <= state_next;
      o_bvalid <= bvalid_next;
    end
  end

  always_ff @(posedge clk) begin
    bst_id    <= bst_id_next;
    bst_addr  <= bst_addr_next;
    bst_size  <= bst_size_next;
    bst_burst <= bst_burst_next;
    o_bid     <= bid_next;
  end

endmodule

`default_nettype wire

// File: axi_mem_array.sv
`default_nettype none

// Word-wide memory, byte-strobed write port, registered read port
module axi_mem_array #(
  parameter int  ADDR_WIDTH      = 8,
  parameter int  DATA_WIDTH      = 32,
  localparam int STRB_WIDTH      = DATA_WIDTH / 8,
  localparam int OFFSET_WIDTH    = $clog2(STRB_WIDTH),
  localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - OFFSET_WIDTH
) (
  input  logic                       clk,

  input  logic                       i_we,
  input  logic [WORD_ADDR_WIDTH-1:0] i_waddr,
  input  logic [DATA_WIDTH-1:0]      i_wdata,
  input  logic [STRB_WIDTH-1:0]      i_wstrb,

  input  logic                       i_re,
  input  logic [WORD_ADDR_WIDTH-1:0] i_raddr,
  output logic [DATA_WIDTH-1:0]      o_rdata
);

  logic [DATA_WIDTH-1:0] mem [2**WORD_ADDR_WIDTH];

  // One byte lane per strobe bit
  always_ff @(posedge clk) begin
    for (int i = 0; i < STRB_WIDTH; i++) begin
      if (i_we && i_wstrb[i]) begin
        mem[i_waddr][8*i +: 8] <= i_wdata[8*i +: 8];
      end
    end
  end

  // Same-cycle write is not visible here, the old word is returned
  always_ff @(posedge clk) begin
    if (i_re) begin
      o_rdata <= mem[i_raddr];
    end
  end

endmodule

`default_nettype wire

// File: axi_skid_buf.sv
`default_nettype none

// Valid/ready skid buffer. Input ready is a register, so one beat that
// arrives while the output stalls is parked in the spare entry.
module axi_skid_buf #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,

  input  logic     i_valid,
  input  payload_t i_data,
  output logic     o_ready,

  output logic     o_valid,
  output payload_t o_data,
  input  logic     i_ready
);

  payload_t skid_data;
  logic     skid_valid;
  logic     skid_valid_next;

  // Pass through while empty, otherwise present the parked entry
  assign o_valid = skid_valid || (i_valid && o_ready);
  assign o_data  = skid_valid ? skid_data : i_data;

  always_comb begin
    if (skid_valid) begin
      // Parked entry leaves once the output takes it
      skid_valid_next = !i_ready;
    end else begin
      skid_valid_next = i_valid && o_ready && !i_ready;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      skid_valid <= 1'b0;
      o_ready    <= 1'b0;
    end else begin
      skid_valid <= skid_valid_next;
      o_ready    <= !skid_valid_next;
    end
  end

  // Spare entry follows the input until it is occupied
  always_ff @(posedge clk) begin
    if (!skid_valid) begin
      skid_data <= i_data;
    end
  end

endmodule

`default_nettype wire

// File: axi_mem_pkg.sv
`default_nettype none

// Engine states and default geometry of the AXI memory
package axi_mem_pkg;

  // Write engine
  typedef enum logic [1:0] {
    WR_IDLE,
    WR_BURST,
    WR_RESP
  } wr_state_e;

  // Read engine
  typedef enum logic {
    RD_IDLE,
    RD_BURST
  } rd_state_e;

  // Default geometry, byte addressed
  localparam int DEF_ADDR_WIDTH = 8;
  localparam int DEF_DATA_WIDTH = 32;
  localparam int DEF_ID_WIDTH   = 4;

endpackage

`default_nettype wire

// File: axi_pkg.sv
`default_nettype none

// AXI4 field widths and the encodings this memory uses
package axi_pkg;

  // ------------------------------------------------
  // Field widths
  // ------------------------------------------------
  localparam int LEN_WIDTH   = 8;
  localparam int SIZE_WIDTH  = 3;
  localparam int BURST_WIDTH = 2;
  localparam int RESP_WIDTH  = 2;

  // ------------------------------------------------
  // Encodings
  // ------------------------------------------------
  // Address holds for every beat of a FIXED burst
  localparam logic [BURST_WIDTH-1:0] BURST_FIXED = 2'b00;

  // Normal access success
  localparam logic [RESP_WIDTH-1:0] RESP_OKAY = 2'b00;

endpackage

`default_nettype wire
